// File: src/tinkerPkg.sv
package tinkerPkg;

    localparam int dataWidth    = 64;     // registers, addresses, ALU results
    localparam int instrWidth   = 32;
    localparam int regAddrWidth = 5;
    localparam int literalWidth = 12;
    localparam int memBytes     = 8192;
    localparam int memAddrWidth = $clog2(memBytes);
    localparam int accessWidth  = 8;      // bytes per data access
    localparam int fetchBytes   = 4;      // bytes per instruction

    // program area starts here, data area lies below
    localparam logic [dataWidth-1:0] resetPc = 64'h1000;

    typedef enum logic [4:0] {
        opAnd     = 5'h00,
        opOr      = 5'h01,
        opXor     = 5'h02,
        opNot     = 5'h03,
        opShftr   = 5'h04,
        opShftri  = 5'h05,
        opShftl   = 5'h06,
        opShftli  = 5'h07,
        opBr      = 5'h08,
        opBrrReg  = 5'h09,
        opBrrLit  = 5'h0A,
        opBrnz    = 5'h0B,
        opBrgt    = 5'h0E,
        opHalt    = 5'h0F,
        opLoad    = 5'h10,
        opMov     = 5'h11,
        opMovLit  = 5'h12,
        opStore   = 5'h13,
        opAdd     = 5'h18,
        opAddi    = 5'h19,
        opSub     = 5'h1A,
        opSubi    = 5'h1B,
        opBubble  = 5'h1F
    } tinkerOpcode;

    // all-zero fields behind the bubble opcode
    localparam logic [instrWidth-1:0] bubbleInstr = {opBubble, {(instrWidth - 5){1'b0}}};

endpackage

// File: src/fetchStage.sv
module fetchStage (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                run,
    input  logic                                stall,
    input  logic                                flush,
    input  logic                                halting,
    input  logic [tinkerPkg::dataWidth-1:0]     branchTarget,
    input  logic                                fetchGrant,
    input  logic [tinkerPkg::instrWidth-1:0]    fetchData,
    output logic                                fetchRequest,
    output logic [tinkerPkg::memAddrWidth-1:0]  fetchAddr,
    output logic [tinkerPkg::instrWidth-1:0]    instruction,
    output logic [tinkerPkg::dataWidth-1:0]     pcPlus4
);
    import tinkerPkg::*;

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] nextPc;

    assign nextPc       = pc + fetchBytes;
    assign fetchRequest = run && !halting;
    assign fetchAddr    = pc[memAddrWidth-1:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc          <= resetPc;
            instruction <= bubbleInstr;
            pcPlus4     <= '0;
        end else if (halting) begin
            instruction <= bubbleInstr;         // frozen, pc stays put
        end else if (flush) begin
            pc          <= branchTarget;
            instruction <= bubbleInstr;
        end else if (!stall) begin
            if (fetchRequest && fetchGrant) begin
                pc          <= nextPc;
                instruction <= fetchData;
                pcPlus4     <= nextPc;
            end else begin
                instruction <= bubbleInstr;     // refused or not running
            end
        end
    end

endmodule

// File: src/registerFile.sv
module registerFile (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                writeEnable,
    input  logic [tinkerPkg::regAddrWidth-1:0]  writeAddr,
    input  logic [tinkerPkg::dataWidth-1:0]     writeData,
    input  logic [tinkerPkg::regAddrWidth-1:0]  readAddrS,
    input  logic [tinkerPkg::regAddrWidth-1:0]  readAddrT,
    input  logic [tinkerPkg::regAddrWidth-1:0]  readAddrD,
    output logic [tinkerPkg::dataWidth-1:0]     readDataS,
    output logic [tinkerPkg::dataWidth-1:0]     readDataT,
    output logic [tinkerPkg::dataWidth-1:0]     readDataD
);
    import tinkerPkg::*;

    logic [dataWidth-1:0] regs [2**regAddrWidth];

    assign readDataS = regs[readAddrS];
    assign readDataT = regs[readAddrT];
    assign readDataD = regs[readAddrD];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;   // visible to decode next cycle
        end
    end

endmodule

// File: src/decodeStage.sv
module decodeStage (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                flush,
    input  logic [tinkerPkg::instrWidth-1:0]    instruction,
    input  logic [tinkerPkg::dataWidth-1:0]     pcPlus4,
    input  logic [tinkerPkg::regAddrWidth-1:0]  exRd,
    input  logic                                exWrite,
    input  logic [tinkerPkg::regAddrWidth-1:0]  wbRd,
    input  logic                                wbWrite,
    input  logic [tinkerPkg::dataWidth-1:0]     wbData,
    output logic                                stall,
    output tinkerPkg::tinkerOpcode              opcode,
    output logic [tinkerPkg::regAddrWidth-1:0]  rd,
    output logic [tinkerPkg::dataWidth-1:0]     operandS,
    output logic [tinkerPkg::dataWidth-1:0]     operandT,
    output logic [tinkerPkg::dataWidth-1:0]     operandD,
    output logic [tinkerPkg::dataWidth-1:0]     literal,
    output logic [tinkerPkg::dataWidth-1:0]     pc,
    output logic                                writesReg
);
    import tinkerPkg::*;

    tinkerOpcode             idOpcode;
    logic [regAddrWidth-1:0] idRd;
    logic [regAddrWidth-1:0] idRs;
    logic [regAddrWidth-1:0] idRt;
    logic [dataWidth-1:0]    idLiteral;
    logic [dataWidth-1:0]    regS;
    logic [dataWidth-1:0]    regT;
    logic [dataWidth-1:0]    regD;
    logic                    idWrites;
    logic                    bubble;

    assign idOpcode  = tinkerOpcode'(instruction[31:27]);
    assign idRd      = instruction[26:22];
    assign idRs      = instruction[21:17];
    assign idRt      = instruction[16:12];
    assign idLiteral = {{(dataWidth - literalWidth){instruction[literalWidth-1]}},
                        instruction[literalWidth-1:0]};

    registerFile regFile (
        .clk         (clk),
        .reset       (reset),
        .writeEnable (wbWrite),
        .writeAddr   (wbRd),
        .writeData   (wbData),
        .readAddrS   (idRs),
        .readAddrT   (idRt),
        .readAddrD   (idRd),
        .readDataS   (regS),
        .readDataT   (regT),
        .readDataD   (regD)
    );

    always_comb begin
        case (idOpcode)
            opAnd, opOr, opXor, opNot, opShftr, opShftri, opShftl, opShftli,
            opLoad, opMov, opMovLit, opAdd, opAddi, opSub, opSubi: idWrites = 1'b1;
            default: idWrites = 1'b0;   // branches, store, halt, bubbles
        endcase
    end

    function automatic logic touches(input logic [regAddrWidth-1:0] dst);
        return (dst == idRs) || (dst == idRt) || (dst == idRd);
    endfunction

    // no forwarding, so wait until the writer has left writeback
    assign stall  = (writesReg && touches(rd)) || (exWrite && touches(exRd)) ||
                    (wbWrite && touches(wbRd));
    assign bubble = stall || flush;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            opcode    <= opBubble;
            writesReg <= 1'b0;
        end else begin
            opcode    <= bubble ? opBubble : idOpcode;
            writesReg <= bubble ? 1'b0 : idWrites;
        end
    end

    always_ff @(posedge clk) begin
        rd       <= idRd;
        operandS <= regS;
        operandT <= regT;
        operandD <= regD;
        literal  <= idLiteral;
        pc       <= pcPlus4 - fetchBytes;
    end

endmodule

// File: src/executeStage.sv
module executeStage (
    input  logic                                clk,
    input  logic                                reset,
    input  tinkerPkg::tinkerOpcode              opcode,
    input  logic [tinkerPkg::regAddrWidth-1:0]  rd,
    input  logic [tinkerPkg::dataWidth-1:0]     operandS,
    input  logic [tinkerPkg::dataWidth-1:0]     operandT,
    input  logic [tinkerPkg::dataWidth-1:0]     operandD,
    input  logic [tinkerPkg::dataWidth-1:0]     literal,
    input  logic [tinkerPkg::dataWidth-1:0]     pc,
    input  logic                                writesReg,
    input  logic [tinkerPkg::dataWidth-1:0]     dataReadData,
    output logic                                dataRequest,
    output logic                                dataWrite,
    output logic [tinkerPkg::memAddrWidth-1:0]  dataAddr,
    output logic [tinkerPkg::dataWidth-1:0]     dataWriteData,
    output logic                                flush,
    output logic [tinkerPkg::dataWidth-1:0]     branchTarget,
    output logic                                halting,
    output logic [tinkerPkg::regAddrWidth-1:0]  exRd,
    output logic                                exWrite,
    output logic [tinkerPkg::regAddrWidth-1:0]  wbRd,
    output logic                                wbWrite,
    output logic [tinkerPkg::dataWidth-1:0]     wbData,
    output logic                                hlt
);
    import tinkerPkg::*;

    logic [dataWidth-1:0] result;
    logic [dataWidth-1:0] address;
    logic [dataWidth-1:0] exResult;
    logic                 taken;
    logic                 isHalt;
    logic                 exHalt;
    logic                 wbHalt;

    always_comb begin
        result       = '0;
        address      = '0;
        taken        = 1'b0;
        isHalt       = 1'b0;
        dataRequest  = 1'b0;
        dataWrite    = 1'b0;
        branchTarget = operandD;    // absolute target unless relative
        case (opcode)
            opAnd:    result = operandS & operandT;
            opOr:     result = operandS | operandT;
            opXor:    result = operandS ^ operandT;
            opNot:    result = ~operandS;
            opShftr:  result = operandS >> operandT[5:0];
            opShftri: result = operandD >> literal;
            opShftl:  result = operandS << operandT[5:0];
            opShftli: result = operandD << literal;
            opBr:     taken = 1'b1;
            opBrrReg: begin
                taken        = 1'b1;
                branchTarget = pc + operandD;
            end
            opBrrLit: begin
                taken        = 1'b1;
                branchTarget = pc + literal;
            end
            opBrnz:   taken = (operandS != '0);
            opBrgt:   taken = ($signed(operandS) > $signed(operandT));
            opHalt:   isHalt = 1'b1;
            opLoad: begin
                address     = operandS + literal;
                dataRequest = 1'b1;
                result      = dataReadData;     // same-cycle read
            end
            opMov:    result = operandS;
            opMovLit: result = {operandD[dataWidth-1:literalWidth], literal[literalWidth-1:0]};
            opStore: begin
                address     = operandD + literal;
                dataRequest = 1'b1;
                dataWrite   = 1'b1;
            end
            opAdd:    result = operandS + operandT;
            opAddi:   result = operandD + literal;
            opSub:    result = operandS - operandT;
            opSubi:   result = operandD - literal;
            default:  result = '0;              // bubble and undefined codes
        endcase
    end

    assign dataAddr      = address[memAddrWidth-1:0];
    assign dataWriteData = operandS;
    assign flush         = taken || isHalt;     // halt also drops younger work
    assign halting       = isHalt || exHalt || wbHalt;
    assign hlt           = wbHalt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exWrite <= 1'b0;
            exHalt  <= 1'b0;
            wbWrite <= 1'b0;
            wbHalt  <= 1'b0;
        end else begin
            exWrite <= writesReg;
            exHalt  <= isHalt;
            wbWrite <= exWrite;
            wbHalt  <= wbHalt || exHalt;        // sticky after retirement
        end
    end

    always_ff @(posedge clk) begin
        exRd     <= rd;
        exResult <= result;
        wbRd     <= exRd;
        wbData   <= exResult;
    end

endmodule

// File: src/memoryArbiter.sv
module memoryArbiter (
    input  logic                                dataRequest,
    input  logic                                dataWrite,
    input  logic [tinkerPkg::memAddrWidth-1:0]  dataAddr,
    input  logic [tinkerPkg::dataWidth-1:0]     dataWriteData,
    input  logic                                hostRequest,
    input  logic                                hostWrite,
    input  logic [tinkerPkg::memAddrWidth-1:0]  hostAddr,
    input  logic [tinkerPkg::dataWidth-1:0]     hostWriteData,
    input  logic                                fetchRequest,
    input  logic [tinkerPkg::memAddrWidth-1:0]  fetchAddr,
    output logic [tinkerPkg::memAddrWidth-1:0]  memAddr,
    output logic                                memWrite,
    output logic [tinkerPkg::dataWidth-1:0]     memWriteData,
    output logic                                hostGrant,
    output logic                                fetchGrant
);
    // data is never refused
    assign hostGrant  = hostRequest && !dataRequest;
    assign fetchGrant = fetchRequest && !dataRequest && !hostRequest;

    always_comb begin
        if (dataRequest) begin
            memAddr = dataAddr;
        end else if (hostRequest) begin
            memAddr = hostAddr;
        end else begin
            memAddr = fetchAddr;   // fetch only reads
        end
    end

    assign memWrite     = dataRequest ? dataWrite : (hostGrant && hostWrite);
    assign memWriteData = dataRequest ? dataWriteData : hostWriteData;

endmodule

// File: src/unifiedMemory.sv
module unifiedMemory (
    input  logic                                clk,
    input  logic [tinkerPkg::memAddrWidth-1:0]  addr,
    input  logic                                writeEnable,
    input  logic [tinkerPkg::dataWidth-1:0]     writeData,
    output logic [tinkerPkg::dataWidth-1:0]     readData
);
    import tinkerPkg::*;

    logic [7:0] bytes [memBytes];

    // little endian, byte address wraps at the top of memory
    always_comb begin
        for (int i = 0; i < accessWidth; i++) begin
            readData[8*i +: 8] = bytes[memAddrWidth'(addr + i)];
        end
    end

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            for (int i = 0; i < accessWidth; i++) begin
                bytes[memAddrWidth'(addr + i)] <= writeData[8*i +: 8];
            end
        end
    end

endmodule

// File: src/tinkerCore.sv
module tinkerCore (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                run,
    input  logic                                hostRequest,
    input  logic                                hostWrite,
    input  logic [tinkerPkg::memAddrWidth-1:0]  hostAddr,
    input  logic [tinkerPkg::dataWidth-1:0]     hostWriteData,
    output logic [tinkerPkg::dataWidth-1:0]     hostReadData,
    output logic                                hostGrant,
    output logic                                hlt
);
    import tinkerPkg::*;

    logic                    fetchRequest;
    logic                    fetchGrant;
    logic [memAddrWidth-1:0] fetchAddr;
    logic [instrWidth-1:0]   instruction;
    logic [dataWidth-1:0]    pcPlus4;
    logic                    stall;
    logic                    flush;
    logic                    halting;
    logic [dataWidth-1:0]    branchTarget;
    tinkerOpcode             opcode;
    logic [regAddrWidth-1:0] rd;
    logic [dataWidth-1:0]    operandS;
    logic [dataWidth-1:0]    operandT;
    logic [dataWidth-1:0]    operandD;
    logic [dataWidth-1:0]    literal;
    logic [dataWidth-1:0]    pc;
    logic                    writesReg;
    logic                    dataRequest;
    logic                    dataWrite;
    logic [memAddrWidth-1:0] dataAddr;
    logic [dataWidth-1:0]    dataWriteData;
    logic [regAddrWidth-1:0] exRd;
    logic                    exWrite;
    logic [regAddrWidth-1:0] wbRd;
    logic                    wbWrite;
    logic [dataWidth-1:0]    wbData;
    logic [memAddrWidth-1:0] memAddr;
    logic                    memWrite;
    logic [dataWidth-1:0]    memWriteData;
    logic [dataWidth-1:0]    memReadData;

    assign hostReadData = memReadData;

    fetchStage fetch (
        .clk(clk), .reset(reset), .run(run), .stall(stall), .flush(flush),
        .halting(halting), .branchTarget(branchTarget), .fetchGrant(fetchGrant),
        .fetchData(memReadData[instrWidth-1:0]), .fetchRequest(fetchRequest),
        .fetchAddr(fetchAddr), .instruction(instruction), .pcPlus4(pcPlus4)
    );

    decodeStage decode (
        .clk(clk), .reset(reset), .flush(flush), .instruction(instruction),
        .pcPlus4(pcPlus4), .exRd(exRd), .exWrite(exWrite), .wbRd(wbRd),
        .wbWrite(wbWrite), .wbData(wbData), .stall(stall), .opcode(opcode), .rd(rd),
        .operandS(operandS), .operandT(operandT), .operandD(operandD),
        .literal(literal), .pc(pc), .writesReg(writesReg)
    );

    executeStage execute (
        .clk(clk), .reset(reset), .opcode(opcode), .rd(rd), .operandS(operandS),
        .operandT(operandT), .operandD(operandD), .literal(literal), .pc(pc),
        .writesReg(writesReg), .dataReadData(memReadData), .dataRequest(dataRequest),
        .dataWrite(dataWrite), .dataAddr(dataAddr), .dataWriteData(dataWriteData),
        .flush(flush), .branchTarget(branchTarget), .halting(halting), .exRd(exRd),
        .exWrite(exWrite), .wbRd(wbRd), .wbWrite(wbWrite), .wbData(wbData), .hlt(hlt)
    );

    memoryArbiter arbiter (
        .dataRequest(dataRequest), .dataWrite(dataWrite), .dataAddr(dataAddr),
        .dataWriteData(dataWriteData), .hostRequest(hostRequest),
        .hostWrite(hostWrite), .hostAddr(hostAddr), .hostWriteData(hostWriteData),
        .fetchRequest(fetchRequest), .fetchAddr(fetchAddr), .memAddr(memAddr),
        .memWrite(memWrite), .memWriteData(memWriteData), .hostGrant(hostGrant),
        .fetchGrant(fetchGrant)
    );

    unifiedMemory memory (
        .clk(clk), .addr(memAddr), .writeEnable(memWrite),
        .writeData(memWriteData), .readData(memReadData)
    );

endmodule

// File: sim/tinkerModel.svh
`ifndef TINKER_MODEL_SVH
`define TINKER_MODEL_SVH

// instruction-level interpreter of the Tinker subset, one instruction per step
logic [7:0]  modelMem [memBytes];
logic [63:0] modelReg [32];

function automatic logic [63:0] modelRead(input logic [63:0] addr);
    logic [63:0] value;
    for (int i = 0; i < 8; i++) begin
        value[8*i +: 8] = modelMem[13'(addr + 64'(i))];     // little endian, wraps
    end
    return value;
endfunction

task automatic modelWrite(input logic [63:0] addr, input logic [63:0] value);
    for (int i = 0; i < 8; i++) begin
        modelMem[13'(addr + 64'(i))] = value[8*i +: 8];
    end
endtask

task automatic modelRun(output bit halted);
    logic [63:0] pc;
    logic [63:0] word;
    logic [63:0] vd;
    logic [63:0] vs;
    logic [63:0] vt;
    logic [63:0] lit;
    logic [63:0] nextPc;
    logic [4:0]  op;
    logic [4:0]  d;
    halted = 1'b0;
    pc     = resetPc;
    for (int r = 0; r < 32; r++) begin
        modelReg[r] = '0;
    end
    for (int step = 0; step < modelStepLimit && !halted; step++) begin
        word   = modelRead(pc);
        op     = word[31:27];
        d      = word[26:22];
        vd     = modelReg[d];
        vs     = modelReg[word[21:17]];
        vt     = modelReg[word[16:12]];
        lit    = {{52{word[11]}}, word[11:0]};      // sign-extended literal
        nextPc = pc + 64'd4;
        case (op)
            opAnd:    modelReg[d] = vs & vt;
            opOr:     modelReg[d] = vs | vt;
            opXor:    modelReg[d] = vs ^ vt;
            opNot:    modelReg[d] = ~vs;
            opShftr:  modelReg[d] = vs >> vt[5:0];
            opShftri: modelReg[d] = vd >> lit;
            opShftl:  modelReg[d] = vs << vt[5:0];
            opShftli: modelReg[d] = vd << lit;
            opBr:     nextPc = vd;
            opBrrReg: nextPc = pc + vd;
            opBrrLit: nextPc = pc + lit;
            opBrnz:   if (vs != '0) nextPc = vd;
            opBrgt:   if ($signed(vs) > $signed(vt)) nextPc = vd;
            opHalt:   halted = 1'b1;
            opLoad:   modelReg[d] = modelRead(vs + lit);
            opMov:    modelReg[d] = vs;
            opMovLit: modelReg[d] = {vd[63:12], word[11:0]};   // upper bits kept
            opStore:  modelWrite(vd + lit, vs);
            opAdd:    modelReg[d] = vs + vt;
            opAddi:   modelReg[d] = vd + lit;
            opSub:    modelReg[d] = vs - vt;
            opSubi:   modelReg[d] = vd - lit;
            default:  ;                                 // undefined codes do nothing
        endcase
        pc = nextPc;
    end
endtask

`endif

// File: sim/tinkerTb.sv
module tinkerTb;
    timeunit 1ns;
    timeprecision 1ps;
    import tinkerPkg::*;

    localparam logic [31:0] seed           = 32'h9caa5490;
    localparam int          bodyLength     = 60;
    localparam int          grantTimeout   = 200;
    localparam int          hltTimeout     = 20000;
    localparam int          modelStepLimit = 10000;
    localparam int          dumpBase       = 'h800;     // register dump of 32 words
    localparam int          dataTop        = 'h1000;

    localparam tinkerOpcode aluOps [14] = '{opAnd, opOr, opXor, opNot, opShftr, opShftri,
        opShftl, opShftli, opAdd, opAddi, opSub, opSubi, opMov, opMovLit};

    logic                    clk;
    logic                    reset;
    logic                    run;
    logic                    hostRequest;
    logic                    hostWrite;
    logic [memAddrWidth-1:0] hostAddr;
    logic [dataWidth-1:0]    hostWriteData;
    logic [dataWidth-1:0]    hostReadData;
    logic                    hostGrant;
    logic                    hlt;

    logic [31:0] codeWords [$];
    int          testErrors;
    int          totalErrors;
    int          testsRun;
    int          testsFailed;

    `include "tinkerModel.svh"

    tinkerCore dut (
        .clk           (clk),
        .reset         (reset),
        .run           (run),
        .hostRequest   (hostRequest),
        .hostWrite     (hostWrite),
        .hostAddr      (hostAddr),
        .hostWriteData (hostWriteData),
        .hostReadData  (hostReadData),
        .hostGrant     (hostGrant),
        .hlt           (hlt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [63:0] fillValue(input int addr);
        return {32'h5eed_0000 | 32'(addr), 32'(addr) * 32'h9e37_79b1};
    endfunction

    // a few hot registers so that hazards are frequent
    function automatic int pickReg();
        return ($urandom % 4 == 0) ? int'($urandom % 30) : int'($urandom % 6);
    endfunction

    task automatic appendInstr(input tinkerOpcode op, input int d, input int s, input int t,
                               input int lit);
        codeWords.push_back({op, d[4:0], s[4:0], t[4:0], lit[11:0]});
    endtask

    task automatic addAluOps(input int count);
        tinkerOpcode op;
        int          lit;
        for (int i = 0; i < count; i++) begin
            op  = aluOps[$urandom % 14];
            lit = (op == opShftri || op == opShftli) ? int'($urandom % 64)
                                                     : int'($urandom % 4096);
            appendInstr(op, pickReg(), pickReg(), pickReg(), lit);
        end
    endtask

    task automatic mixMemOps(input int count);
        int addr;
        for (int i = 0; i < count; i++) begin
            addr = 8 * int'($urandom % 256);            // below the dump area
            appendInstr(opXor, 30, 30, 30, 0);           // r30 = 0 as base
            if ($urandom % 2 == 0) begin
                appendInstr(opStore, 30, pickReg(), 0, addr);
            end else begin
                appendInstr(opLoad, pickReg(), 30, 0, addr);
            end
            addAluOps(1);
        end
    endtask

    task automatic insertBranch();
        int skip;
        int kind;
        int target;
        skip   = 1 + int'($urandom % 3);
        kind   = int'($urandom % 5);
        target = int'(resetPc) + 4 * (codeWords.size() + 4 + skip);   // 3 setup words
        appendInstr(opXor, 29, 29, 29, 0);
        appendInstr(opMovLit, 29, 0, 0, (kind == 1) ? skip + 1 : target >> 2);
        appendInstr(opShftli, 29, 0, 0, 2);
        case (kind)
            0: appendInstr(opBr, 29, 0, 0, 0);
            1: appendInstr(opBrrReg, 29, 0, 0, 0);
            2: appendInstr(opBrrLit, 0, 0, 0, 4 * (skip + 1));
            3: appendInstr(opBrnz, 29, pickReg(), 0, 0);
            default: appendInstr(opBrgt, 29, pickReg(), pickReg(), 0);
        endcase
        for (int i = 0; i < skip; i++) begin
            appendInstr(opMovLit, pickReg(), 0, 0, 'hbad);     // marks a skipped write
        end
    endtask

    task automatic storeRegisters();
        appendInstr(opXor, 31, 31, 31, 0);
        appendInstr(opMovLit, 31, 0, 0, dumpBase);
        for (int r = 0; r < 32; r++) begin
            appendInstr(opStore, 31, r, 0, 8 * r);
        end
        appendInstr(opHalt, 0, 0, 0, 0);
        appendInstr(opStore, 31, 0, 0, 'h100);                 // right behind halt
    endtask

    task automatic applyReset();
        reset       = 1'b1;
        run         = 1'b0;
        hostRequest = 1'b0;
        hostWrite   = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    // one host access held until granted
    task automatic hostTransfer(input logic write, input int addr, input logic [63:0] wdata,
                                output logic [63:0] rdata);
        int waited;
        hostRequest   = 1'b1;
        hostWrite     = write;
        hostAddr      = memAddrWidth'(addr);
        hostWriteData = wdata;
        waited        = 0;
        @(negedge clk);
        while (!hostGrant && waited < grantTimeout) begin
            @(negedge clk);
            waited++;
        end
        rdata = hostReadData;
        if (!hostGrant) begin
            $display("timeout at %0t: host access to 0x%03h was never granted", $time, addr);
            testErrors++;
        end
        @(posedge clk);
        #1;
        hostRequest = 1'b0;
        hostWrite   = 1'b0;
    endtask

    task automatic compareWord(input int addr, input logic [63:0] got);
        logic [63:0] expected;
        expected = modelRead(64'(addr));
        if (got !== expected) begin
            $display("error at %0t: mem[0x%03h] = 0x%h, expected 0x%h",
                     $time, addr, got, expected);
            testErrors++;
        end
    endtask

    task automatic reportTest(input string name);
        testsRun++;
        totalErrors += testErrors;
        if (testErrors != 0) begin
            testsFailed++;
        end
        $display("test %-14s %s (%0d errors)", name, (testErrors == 0) ? "ok" : "failed",
                 testErrors);
    endtask

    task automatic resetTest();
        testErrors = 0;
        applyReset();
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (hlt !== 1'b0) begin
                $display("error at %0t: hlt = %b with run low, expected 0", $time, hlt);
                testErrors++;
            end
        end
        @(posedge clk);
        #1;
        reportTest("reset");
    endtask

    // loads codeWords, runs it on model and DUT, compares the data area
    task automatic runProgram(input string name, input int hostReads);
        logic [63:0] word;
        bit          halted;
        int          waited;
        int          addr;
        testErrors = 0;
        applyReset();
        for (int i = 0; i < memBytes; i++) begin
            modelMem[i] = '0;
        end
        for (addr = 0; addr < dataTop; addr += 8) begin
            modelWrite(64'(addr), fillValue(addr));
            hostTransfer(1'b1, addr, fillValue(addr), word);
        end
        if (codeWords.size() % 2 != 0) begin
            codeWords.push_back('0);
        end
        for (int i = 0; i < codeWords.size(); i += 2) begin
            addr = int'(resetPc) + 4 * i;
            modelWrite(64'(addr), {codeWords[i+1], codeWords[i]});
            hostTransfer(1'b1, addr, {codeWords[i+1], codeWords[i]}, word);
        end
        modelRun(halted);
        if (!halted) begin
            $display("model ran %0d steps without reaching halt", modelStepLimit);
            testErrors++;
        end
        run = 1'b1;
        for (int k = 0; k < hostReads; k++) begin
            repeat (2 + $urandom % 16) @(posedge clk);  // lands among data accesses
            #1;
            addr = 'hc00 + 8 * int'($urandom % 64);     // never written by the program
            hostTransfer(1'b0, addr, '0, word);
            compareWord(addr, word);
        end
        waited = 0;
        while (!hlt && waited < hltTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (!hlt) begin
            $display("timeout at %0t: hlt did not rise within %0d cycles", $time, hltTimeout);
            testErrors++;
        end
        @(posedge clk);
        #1;
        for (addr = 0; addr < dataTop; addr += 8) begin
            hostTransfer(1'b0, addr, '0, word);
            compareWord(addr, word);
        end
        if (hlt !== 1'b1) begin
            $display("error at %0t: hlt = %b after readback, expected 1", $time, hlt);
            testErrors++;
        end
        run = 1'b0;
        reportTest(name);
    endtask

    initial begin
        reset         = 1'b1;
        run           = 1'b0;
        hostRequest   = 1'b0;
        hostWrite     = 1'b0;
        hostAddr      = '0;
        hostWriteData = '0;
        void'($urandom(seed));
        testsRun      = 0;
        testsFailed   = 0;
        totalErrors   = 0;

        resetTest();

        codeWords.delete();
        addAluOps(bodyLength);
        storeRegisters();
        runProgram("straightLine", 0);

        codeWords.delete();
        mixMemOps(30);
        storeRegisters();
        runProgram("loadStore", 0);

        codeWords.delete();
        repeat (8) begin
            addAluOps(4);
            insertBranch();
        end
        storeRegisters();
        runProgram("branch", 0);

        codeWords.delete();
        addAluOps(20);
        storeRegisters();
        addAluOps(4);
        appendInstr(opStore, 31, 1, 0, 'h180);                 // well past the halt
        runProgram("halt", 0);

        codeWords.delete();
        mixMemOps(40);
        storeRegisters();
        runProgram("hostDuringRun", 12);

        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, totalErrors);
        if (testsFailed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: tinkerPipe.f
+incdir+sim
src/tinkerPkg.sv
src/fetchStage.sv
src/registerFile.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryArbiter.sv
src/unifiedMemory.sv
src/tinkerCore.sv
sim/tinkerTb.sv

// File: run.sh
#!/bin/sh
# builds the tinkerPipe testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tinkerPipe.f --top-module tinkerTb -o tinkerSim

output=$(./obj_dir/tinkerSim)
echo "$output"

# the run counts as passed only if the pass line was printed
echo "$output" | grep -qxF '*** PASSED ***'
